// File: verilog/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int DATA_W    = 16;
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 16;
    localparam int IB_DEPTH  = 4;
    localparam int RS_DEPTH  = 4;
    localparam int ROB_DEPTH = 8;
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS; // tags not mapped at reset
    localparam int IMM_W     = 7;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_idx_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [$clog2(RS_DEPTH)-1:0]  rs_idx_t;
    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [IMM_W-1:0]             imm_t;

    ////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sltu, // unsigned set-less-than
        op_addi,
        op_li    // rs1 ignored
    } op_e;

    typedef struct packed {
        op_e       op;
        arch_idx_t rd;
        arch_idx_t rs1;
        arch_idx_t rs2;
        logic [3:0] unused;
    } inst_reg_t;

    typedef struct packed {
        op_e       op;
        arch_idx_t rd;
        arch_idx_t rs1;
        imm_t      imm; // sign extended at use
    } inst_imm_t;

    typedef union packed {
        inst_reg_t rtype;
        inst_imm_t itype;
    } inst_t;

    ////////////////////////////////////////
    // stage packets
    ////////////////////////////////////////

    typedef struct packed {
        op_e       op;
        logic      use_imm;
        phys_idx_t src1;
        logic      src1_rdy;
        phys_idx_t src2;
        logic      src2_rdy;
        phys_idx_t dest;
        rob_idx_t  rob_idx;
        imm_t      imm;
    } renamed_t;

    typedef struct packed {
        logic      valid;
        phys_idx_t dest;
        rob_idx_t  rob_idx;
        data_t     value;
    } cdb_t;

    typedef struct packed {
        arch_idx_t rd;
        data_t     value;
    } commit_t;

endpackage

// File: verilog/inst_buffer.sv
module inst_buffer
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    input  inst_t      in_inst,
    input  logic       pop,
    output logic       ib_valid,
    output inst_t      head_inst,
    output logic [2:0] ib_open
);

    typedef logic [$clog2(IB_DEPTH+1)-1:0] cnt_t;

    inst_t buffer [IB_DEPTH];
    logic [$clog2(IB_DEPTH)-1:0] head, tail;
    cnt_t count;

    assign ib_valid  = count != 0;
    assign head_inst = buffer[head];
    assign ib_open   = 3'(IB_DEPTH) - count; // credits for the producer

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (in_valid) tail <= tail + 1'b1;
            if (pop)      head <= head + 1'b1;
            count <= count + cnt_t'(in_valid) - cnt_t'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            buffer[tail] <= in_inst;
        end
    end

    // producer has to respect the credit count
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        in_valid |-> ib_open != 0)
        else $error("instruction sent with no open buffer entry");

endmodule

// File: verilog/rename.sv
module rename
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      ib_valid,
    input  inst_t     head_inst,
    input  logic      rob_full,
    input  logic      rs_full,
    input  phys_idx_t free_tag,
    input  cdb_t      cdb,
    input  rob_idx_t  rob_tail,
    output logic      dispatch,
    output renamed_t  renamed,
    output phys_idx_t old_tag
);

    phys_idx_t map_table [ARCH_REGS];
    logic [PHYS_REGS-1:0] ready; // value present in the regfile
    op_e op;
    arch_idx_t rd;
    logic use_imm;

    assign op       = head_inst.rtype.op;
    assign rd       = head_inst.rtype.rd;
    assign use_imm  = (op == op_addi) || (op == op_li);
    assign dispatch = ib_valid && !rob_full && !rs_full;
    assign old_tag  = map_table[rd];

    always_comb begin
        renamed.op       = op;
        renamed.use_imm  = use_imm;
        renamed.src1     = map_table[head_inst.rtype.rs1];
        renamed.src1_rdy = ready[renamed.src1] || (op == op_li); // li reads nothing
        // imm bits alias rs2 here, the tag is don't-care
        renamed.src2     = map_table[head_inst.rtype.rs2];
        renamed.src2_rdy = ready[renamed.src2] || use_imm;
        renamed.dest     = free_tag;
        renamed.rob_idx  = rob_tail;
        renamed.imm      = head_inst.itype.imm;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_table[i] <= phys_idx_t'(i); // identity mapping
            end
            ready <= '1;
        end else begin
            if (cdb.valid) ready[cdb.dest] <= 1'b1;
            if (dispatch) begin
                map_table[rd]   <= free_tag;
                ready[free_tag] <= 1'b0; // free tag never matches the bus
            end
        end
    end

endmodule

// File: verilog/free_list.sv
module free_list
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      pop,
    input  logic      push,
    input  phys_idx_t push_tag,
    output phys_idx_t free_tag
);

    typedef logic [$clog2(FREE_REGS+1)-1:0] cnt_t;

    phys_idx_t fifo [FREE_REGS];
    logic [$clog2(FREE_REGS)-1:0] head, tail;
    cnt_t count;

    assign free_tag = fifo[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_REGS; i++) begin
                fifo[i] <= phys_idx_t'(ARCH_REGS + i); // upper tags start free
            end
            head  <= '0;
            tail  <= '0; // full, so tail wrapped onto head
            count <= cnt_t'(FREE_REGS);
        end else begin
            if (push) begin
                fifo[tail] <= push_tag;
                tail       <= tail + 1'b1;
            end
            if (pop) head <= head + 1'b1;
            count <= count + cnt_t'(push) - cnt_t'(pop);
        end
    end

    // empty list only while the ROB is full, which blocks dispatch
    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        pop |-> count != 0)
        else $error("free list popped while empty");

endmodule

// File: verilog/reservation_station.sv
module reservation_station
    import core_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch,
    input  renamed_t renamed,
    input  cdb_t     cdb,
    output logic     rs_full,
    output logic     issue_valid,
    output renamed_t issue
);

    renamed_t entry [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy;
    logic [RS_DEPTH-1:0] wake_1, wake_2;
    logic [RS_DEPTH-1:0] ready_now;
    rs_idx_t alloc_idx, issue_sel;
    renamed_t incoming;

    ////////////////////////////////////////
    // wakeup and select
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake_1[i]    = cdb.valid && (cdb.dest == entry[i].src1);
            wake_2[i]    = cdb.valid && (cdb.dest == entry[i].src2);
            // bus value is bypassed in the regfile, so issue this cycle
            ready_now[i] = busy[i] && (entry[i].src1_rdy || wake_1[i])
                                   && (entry[i].src2_rdy || wake_2[i]);
        end
    end

    always_comb begin
        alloc_idx = '0;
        issue_sel = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin // lowest index wins
            if (!busy[i])     alloc_idx = rs_idx_t'(i);
            if (ready_now[i]) issue_sel = rs_idx_t'(i);
        end
    end

    assign rs_full     = &busy;
    assign issue_valid = |ready_now;
    assign issue       = entry[issue_sel];

    // producer may broadcast in the dispatch cycle
    always_comb begin
        incoming = renamed;
        if (cdb.valid && cdb.dest == renamed.src1) incoming.src1_rdy = 1'b1;
        if (cdb.valid && cdb.dest == renamed.src2) incoming.src2_rdy = 1'b1;
    end

    ////////////////////////////////////////
    // entry state
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (issue_valid) busy[issue_sel] <= 1'b0;
            if (dispatch)    busy[alloc_idx] <= 1'b1; // never the issuing slot
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wake_1[i]) entry[i].src1_rdy <= 1'b1;
            if (wake_2[i]) entry[i].src2_rdy <= 1'b1;
        end
        if (dispatch) entry[alloc_idx] <= incoming;
    end

endmodule

// File: verilog/phys_regfile.sv
module phys_regfile
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  phys_idx_t rd_tag_1,
    input  phys_idx_t rd_tag_2,
    output data_t     rd_data_1,
    output data_t     rd_data_2,
    input  cdb_t      cdb
);

    data_t regs [PHYS_REGS];

    // write-through from the bus
    assign rd_data_1 = (cdb.valid && cdb.dest == rd_tag_1) ? cdb.value : regs[rd_tag_1];
    assign rd_data_2 = (cdb.valid && cdb.dest == rd_tag_2) ? cdb.value : regs[rd_tag_2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb.valid) begin
            regs[cdb.dest] <= cdb.value;
        end
    end

endmodule

// File: verilog/alu.sv
module alu
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      issue_valid,
    input  renamed_t  issue,
    output phys_idx_t rd_tag_1,
    output phys_idx_t rd_tag_2,
    input  data_t     rd_data_1,
    input  data_t     rd_data_2,
    output cdb_t      cdb
);

    data_t imm_ext, op_b, result;
    logic res_valid;
    phys_idx_t res_dest;
    rob_idx_t res_rob;
    data_t res_value;

    assign rd_tag_1 = issue.src1;
    assign rd_tag_2 = issue.src2;
    assign imm_ext  = {{(DATA_W - IMM_W){issue.imm[IMM_W-1]}}, issue.imm};
    assign op_b     = issue.use_imm ? imm_ext : rd_data_2;

    always_comb begin
        case (issue.op)
            op_add, op_addi: result = rd_data_1 + op_b;
            op_sub:          result = rd_data_1 - op_b;
            op_and:          result = rd_data_1 & op_b;
            op_or:           result = rd_data_1 | op_b;
            op_xor:          result = rd_data_1 ^ op_b;
            op_sltu:         result = data_t'(rd_data_1 < op_b);
            op_li:           result = imm_ext;
            default:         result = '0;
        endcase
    end

    // result register drives the bus
    always_ff @(posedge clock) begin
        if (reset) res_valid <= 1'b0;
        else       res_valid <= issue_valid;
    end

    always_ff @(posedge clock) begin
        res_dest  <= issue.dest;
        res_rob   <= issue.rob_idx;
        res_value <= result;
    end

    assign cdb = '{valid: res_valid, dest: res_dest, rob_idx: res_rob, value: res_value};

endmodule

// File: verilog/reorder_buffer.sv
module reorder_buffer
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch,
    input  renamed_t  renamed,
    input  arch_idx_t rd,
    input  phys_idx_t old_tag,
    input  cdb_t      cdb,
    output logic      rob_full,
    output rob_idx_t  rob_tail,
    output logic      commit_valid,
    output commit_t   commit,
    output logic      free_push,
    output phys_idx_t free_tag_out
);

    typedef logic [$clog2(ROB_DEPTH+1)-1:0] cnt_t;

    arch_idx_t rd_q    [ROB_DEPTH];
    phys_idx_t old_q   [ROB_DEPTH];
    data_t     value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;
    rob_idx_t head, tail;
    cnt_t count;
    logic retire;

    assign rob_full = count == cnt_t'(ROB_DEPTH);
    assign rob_tail = tail;
    assign retire   = done[head]; // done only ever set on live entries

    assign commit_valid = retire;
    assign commit       = '{rd: rd_q[head], value: value_q[head]};
    assign free_push    = retire;
    assign free_tag_out = old_q[head]; // previous mapping is dead now

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (dispatch) tail <= tail + 1'b1;
            if (retire) begin
                head       <= head + 1'b1;
                done[head] <= 1'b0;
            end
            if (cdb.valid) done[cdb.rob_idx] <= 1'b1;
            count <= count + cnt_t'(dispatch) - cnt_t'(retire);
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch) begin
            rd_q[renamed.rob_idx]  <= rd;
            old_q[renamed.rob_idx] <= old_tag;
        end
        if (cdb.valid) value_q[cdb.rob_idx] <= cdb.value;
    end

    // bus must complete a live, unfinished entry
    a_cdb_live: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (rob_idx_t'(cdb.rob_idx - head) < count) && !done[cdb.rob_idx])
        else $error("bus result for an entry that is not in flight");

endmodule

// File: verilog/ooo_core.sv
module ooo_core
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    input  inst_t      in_inst,
    output logic [2:0] ib_open,
    output logic       commit_valid,
    output commit_t    commit
);

    ////////////////////////////////////////
    // stage wires
    ////////////////////////////////////////

    logic      ib_valid;
    inst_t     ib_head;
    logic      dispatch;
    renamed_t  renamed;
    phys_idx_t old_tag;
    phys_idx_t free_tag;
    logic      rob_full, rs_full;
    rob_idx_t  rob_tail;
    logic      issue_valid;
    renamed_t  issue;
    phys_idx_t rd_tag_1, rd_tag_2;
    data_t     rd_data_1, rd_data_2;
    cdb_t      cdb;
    logic      free_push;
    phys_idx_t free_tag_out;

    ////////////////////////////////////////
    // front end
    ////////////////////////////////////////

    inst_buffer inst_buffer_i (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst),
        .pop(dispatch),
        .ib_valid(ib_valid), .head_inst(ib_head), .ib_open(ib_open)
    );

    rename rename_i (
        .clock(clock), .reset(reset),
        .ib_valid(ib_valid), .head_inst(ib_head),
        .rob_full(rob_full), .rs_full(rs_full),
        .free_tag(free_tag), .cdb(cdb), .rob_tail(rob_tail),
        .dispatch(dispatch), .renamed(renamed), .old_tag(old_tag)
    );

    free_list free_list_i (
        .clock(clock), .reset(reset),
        .pop(dispatch), .push(free_push), .push_tag(free_tag_out),
        .free_tag(free_tag)
    );

    ////////////////////////////////////////
    // issue, execute, retire
    ////////////////////////////////////////

    reservation_station reservation_station_i (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .renamed(renamed), .cdb(cdb),
        .rs_full(rs_full), .issue_valid(issue_valid), .issue(issue)
    );

    phys_regfile phys_regfile_i (
        .clock(clock), .reset(reset),
        .rd_tag_1(rd_tag_1), .rd_tag_2(rd_tag_2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .cdb(cdb)
    );

    alu alu_i (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue(issue),
        .rd_tag_1(rd_tag_1), .rd_tag_2(rd_tag_2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .cdb(cdb)
    );

    reorder_buffer reorder_buffer_i (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .renamed(renamed),
        .rd(ib_head.rtype.rd), // same field in both formats
        .old_tag(old_tag), .cdb(cdb),
        .rob_full(rob_full), .rob_tail(rob_tail),
        .commit_valid(commit_valid), .commit(commit),
        .free_push(free_push), .free_tag_out(free_tag_out)
    );

endmodule

// File: bench/commit_checker.sv
module commit_checker
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    input  inst_t      in_inst,
    input  logic [2:0] ib_open,
    input  logic       commit_valid,
    input  commit_t    commit,
    output int         accept_count,
    output int         commit_count,
    output int         error_count
);

    inst_t   pending [$]; // accepted, not yet committed
    data_t   model_regs [ARCH_REGS];
    inst_t   word;
    commit_t expected;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // architectural result of one word, applied to the model in input order
    function commit_t reference_result(input inst_t w);
        data_t   a;
        data_t   b;
        data_t   imm;
        commit_t result;
        a   = model_regs[w.rtype.rs1];
        b   = model_regs[w.rtype.rs2];
        imm = data_t'(signed'(w.itype.imm)); // 7-bit two's complement
        case (w.rtype.op)
            op_add:  result.value = a + b;
            op_sub:  result.value = a - b;
            op_and:  result.value = a & b;
            op_or:   result.value = a | b;
            op_xor:  result.value = a ^ b;
            op_sltu: result.value = (a < b) ? 16'd1 : 16'd0;
            op_addi: result.value = a + imm;
            default: result.value = imm; // li
        endcase
        result.rd = w.rtype.rd;
        model_regs[w.rtype.rd] = result.value;
        return result;
    endfunction

    ////////////////////////////////////////
    // compare on each commit, then record input
    ////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            pending.delete();
            for (int i = 0; i < ARCH_REGS; i++) begin
                model_regs[i] = '0;
            end
            accept_count = 0;
            commit_count = 0;
            error_count  = 0;
        end else begin
            if (commit_valid) begin
                commit_count++;
                if (pending.size() == 0) begin
                    error_count++;
                    $display("ERROR %0t: commit with no instruction in flight", $time);
                end else begin
                    word     = pending.pop_front();
                    expected = reference_result(word);
                    if (commit !== expected) begin
                        error_count++;
                        $display("ERROR %0t: commit rd %0d value %h, expected rd %0d value %h",
                                 $time, commit.rd, commit.value, expected.rd, expected.value);
                    end
                end
            end
            if (ib_open > 3'd4) begin
                error_count++;
                $display("ERROR %0t: ib_open is %0d, above the buffer depth", $time, ib_open);
            end
            if (in_valid) begin
                if (ib_open == 3'd0) begin
                    error_count++;
                    $display("ERROR %0t: word sent with no open buffer entry", $time);
                end
                pending.push_back(in_inst); // taken at this edge
                accept_count++;
            end
        end
    end

endmodule

// File: bench/ooo_core_tb.sv
module ooo_core_tb
    import core_pkg::*;
();

    localparam int WAIT_LIMIT   = 200;
    localparam int DRAIN_LIMIT  = 500;
    localparam int RANDOM_WORDS = 300;
    localparam int BURST_WORDS  = 200;

    logic        clock;
    logic        reset;
    logic        in_valid;
    inst_t       in_inst;
    logic [2:0]  ib_open;
    logic        commit_valid;
    commit_t     commit;
    int          accept_count, commit_count, checker_errors;
    int          bench_errors;
    int          gap;
    logic [31:0] raw_bits; // LFSR output, low 16 bits form a word
    logic [31:0] lfsr;

    always #10 clock = ~clock;

    ooo_core ooo_core_i (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst), .ib_open(ib_open),
        .commit_valid(commit_valid), .commit(commit)
    );

    commit_checker commit_checker_i (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst), .ib_open(ib_open),
        .commit_valid(commit_valid), .commit(commit),
        .accept_count(accept_count), .commit_count(commit_count),
        .error_count(checker_errors)
    );

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // taps 32, 22, 2, 1
    function logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function inst_t reg_word(input op_e op, input int rd, input int rs1, input int rs2);
        inst_t w;
        w              = '0;
        w.rtype.op     = op;
        w.rtype.rd     = arch_idx_t'(rd);
        w.rtype.rs1    = arch_idx_t'(rs1);
        w.rtype.rs2    = arch_idx_t'(rs2);
        return w;
    endfunction

    function inst_t imm_word(input op_e op, input int rd, input int rs1, input int imm);
        inst_t w;
        w           = '0;
        w.itype.op  = op;
        w.itype.rd  = arch_idx_t'(rd);
        w.itype.rs1 = arch_idx_t'(rs1);
        w.itype.imm = imm_t'(imm);
        return w;
    endfunction

    task abort_run(input string reason);
        $display("timeout: %s", reason);
        $display("accepted %0d committed %0d errors %0d",
                 accept_count, commit_count, checker_errors + bench_errors);
        $display("Simulation failed");
        $finish;
    endtask

    // called at edge plus 2, returns at edge plus 2
    task send_word(input inst_t w);
        int waited;
        waited = 0;
        while (ib_open == 3'd0) begin // hold off until a credit opens
            @(posedge clock);
            #2;
            waited++;
            if (waited > WAIT_LIMIT) abort_run("no open buffer entry for a new word");
        end
        in_valid = 1'b1;
        in_inst  = w;
        @(posedge clock);
        #2;
        in_valid = 1'b0;
    endtask

    task wait_for_drain;
        int waited;
        waited = 0;
        while (commit_count != accept_count) begin
            @(posedge clock);
            #2;
            waited++;
            if (waited > DRAIN_LIMIT) abort_run("commits did not catch up with accepted words");
        end
        repeat (5) @(posedge clock); // catch stray extra commits
        #2;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_inst      = '0;
        lfsr         = 32'h80254745;
        bench_errors = 0;
        raw_bits     = '0;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        // idle after reset
        repeat (4) begin
            if (ib_open !== 3'd4 || commit_valid !== 1'b0) begin
                bench_errors++;
                $display("ERROR %0t: after reset ib_open %0d commit_valid %b, expected 4 and 0",
                         $time, ib_open, commit_valid);
            end
            @(posedge clock);
            #2;
        end

        for (int i = 0; i < ARCH_REGS; i++) begin
            send_word(imm_word(op_li, i, 0, i * 17 - 64)); // -64 up to 55
        end
        for (int op = 0; op < 6; op++) begin
            send_word(reg_word(op_e'(op), op, op + 1, 7 - op));
        end
        send_word(reg_word(op_sltu, 6, 0, 7));
        send_word(reg_word(op_sltu, 7, 7, 0));
        send_word(imm_word(op_addi, 2, 5, -1));
        send_word(imm_word(op_addi, 4, 4, -64));
        send_word(imm_word(op_addi, 0, 3, 63));

        // repeated rd where each one reads the last result
        for (int i = 0; i < 10; i++) begin
            send_word(imm_word(op_addi, 1, 1, 3 - i));
        end
        for (int i = 0; i < 12; i++) begin
            send_word(reg_word(op_add, (i + 2) % 8, (i + 1) % 8, (i + 1) % 8));
            send_word(reg_word(op_sub, (i + 3) % 8, (i + 2) % 8, i % 8));
        end
        // every register renamed many times over
        for (int pass_n = 0; pass_n < 6; pass_n++) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                send_word(reg_word(op_e'((pass_n + r) % 6), r, (r + 7) % 8, (r + pass_n) % 8));
            end
        end

        // random words with random idle gaps
        repeat (RANDOM_WORDS) begin
            raw_bits = random_bits(16);
            send_word(inst_t'(raw_bits[15:0]));
            gap = random_bits(2);
            repeat (gap) begin
                @(posedge clock);
                #2;
            end
        end

        // in_valid held whenever a credit is open
        repeat (BURST_WORDS) begin
            raw_bits = random_bits(16);
            send_word(inst_t'(raw_bits[15:0]));
        end

        wait_for_drain();
        $display("accepted %0d committed %0d errors %0d",
                 accept_count, commit_count, checker_errors + bench_errors);
        if (checker_errors + bench_errors == 0 && commit_count == accept_count) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/core_pkg.sv
verilog/inst_buffer.sv
verilog/rename.sv
verilog/free_list.sv
verilog/reservation_station.sv
verilog/phys_regfile.sv
verilog/alu.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
bench/commit_checker.sv
bench/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module ooo_core_tb -o ooo_core_sim
output=$(./obj_dir/ooo_core_sim)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
